// File: Bender.yml
package:
  name: ldq

sources:
  - include_dirs:
      - hw
    files:
      - hw/ldq_core_pkg.sv
      - hw/ldq_lsu_pkg.sv
      - hw/ldq_entry.sv
      - hw/ldq_select.sv
      - hw/ldq.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/ldq_chk.sv
      - tb/tb_ldq_checker.sv
      - tb/tb_ldq.sv

// File: hw/ldq.sv
`timescale 1ns/100ps
`default_nettype none

`include "ldq_defines.svh"

module ldq
  import ldq_core_pkg::*, ldq_lsu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,

  input  logic         i_disp_valid,
  input  disp_t        i_disp,
  input  cmt_id_t      i_disp_cmt_id,

  input  phy_wr_t      i_phy_wr [`PHY_WR_NUM],
  input  logic         i_pipe_ready,

  input  ex1_upd_t     i_ex1,
  input  ex2_upd_t     i_ex2,
  input  logic         i_tlb_resolve,
  input  lrq_resolve_t i_lrq_resolve,
  input  logic         i_lrq_full,
  input  stq_resolve_t i_stq_resolve,

  input  commit_t      i_commit,
  input  br_upd_t      i_br_upd,

  output logic         o_issue_valid,
  output ldq_idx_t     o_issue_idx,
  output cmt_id_t      o_issue_cmt_id,
  output logic         o_finish_valid,
  output cmt_id_t      o_finish_cmt_id,
  output logic         o_full
);

  logic [`LDQ_SIZE-1:0] w_free;
  logic [`LDQ_SIZE-1:0] w_ready;
  logic [`LDQ_SIZE-1:0] w_finish;
  logic [`LDQ_SIZE-1:0] w_alloc_oh;
  logic [`LDQ_SIZE-1:0] w_issue_oh;
  cmt_id_t              w_cmt_id [`LDQ_SIZE];

  for (genvar g_idx = 0; g_idx < `LDQ_SIZE; g_idx++) begin : g_entry
    ldq_entry u_entry (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_disp_load   (i_disp_valid & w_alloc_oh[g_idx]),  // lost when full
      .i_disp        (i_disp),
      .i_disp_cmt_id (i_disp_cmt_id),
      .i_phy_wr      (i_phy_wr),
      .i_picked      (w_issue_oh[g_idx]),
      .i_ex1         (i_ex1),
      .i_ex2         (i_ex2),
      .i_my_idx      (ldq_idx_t'(g_idx)),
      .i_tlb_resolve (i_tlb_resolve),
      .i_lrq_resolve (i_lrq_resolve),
      .i_lrq_full    (i_lrq_full),
      .i_stq_resolve (i_stq_resolve),
      .i_commit      (i_commit),
      .i_br_upd      (i_br_upd),
      .o_ready       (w_ready[g_idx]),
      .o_free        (w_free[g_idx]),
      .o_finish      (w_finish[g_idx]),
      .o_cmt_id      (w_cmt_id[g_idx])
    );
  end

  ldq_select u_select (
    .i_free        (w_free),
    .i_ready       (w_ready),
    .i_pipe_ready  (i_pipe_ready),
    .o_alloc_oh    (w_alloc_oh),
    .o_full        (o_full),
    .o_issue_oh    (w_issue_oh),
    .o_issue_valid (o_issue_valid),
    .o_issue_idx   (o_issue_idx)
  );

  assign o_finish_valid = |w_finish;

  // one-hot and-or muxes, at most one finisher per commit id
  always_comb begin
    o_issue_cmt_id  = '0;
    o_finish_cmt_id = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      o_issue_cmt_id  |= w_issue_oh[i] ? w_cmt_id[i] : '0;
      o_finish_cmt_id |= w_finish[i] ? w_cmt_id[i] : '0;
    end
  end

endmodule

`default_nettype wire

// File: hw/ldq_core_pkg.sv
`default_nettype none

`include "ldq_defines.svh"

package ldq_core_pkg;

  typedef logic [`CMT_ID_W-1:0]          cmt_id_t;
  typedef logic [`RNID_W-1:0]            rnid_t;
  typedef logic [$clog2(`BRTAG_NUM)-1:0] brtag_t;
  typedef logic [`BRTAG_NUM-1:0]         br_mask_t;

  // dispatched load, operands and branch dependence
  typedef struct packed {
    logic     rs1_valid;
    rnid_t    rs1_rnid;
    logic     rs2_valid;
    rnid_t    rs2_rnid;
    br_mask_t br_mask;
  } disp_t;

  // retirement of one instruction
  typedef struct packed {
    logic    valid;
    cmt_id_t cmt_id;
    logic    flush;  // flush everything but this one
  } commit_t;

  typedef struct packed {
    logic   update;
    logic   mispredict;
    brtag_t brtag;
  } br_upd_t;

  // register write result
  typedef struct packed {
    logic  valid;
    rnid_t rnid;
  } phy_wr_t;

endpackage

`default_nettype wire

// File: hw/ldq_defines.svh
`ifndef LDQ_DEFINES_SVH
`define LDQ_DEFINES_SVH

// load queue geometry
`define LDQ_SIZE   4

// neighbour queues in the load unit
`define LRQ_SIZE   4
`define STQ_SIZE   4

// core side widths
`define CMT_ID_W   6
`define RNID_W     6
`define BRTAG_NUM  4  // also the mask width

`define PHY_WR_NUM 2  // register write buses

`endif

// File: hw/ldq_entry.sv
`timescale 1ns/100ps
`default_nettype none

`include "ldq_defines.svh"

module ldq_entry
  import ldq_core_pkg::*, ldq_lsu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,

  input  logic         i_disp_load,
  input  disp_t        i_disp,
  input  cmt_id_t      i_disp_cmt_id,

  input  phy_wr_t      i_phy_wr [`PHY_WR_NUM],

  input  logic         i_picked,
  input  ex1_upd_t     i_ex1,
  input  ex2_upd_t     i_ex2,
  input  ldq_idx_t     i_my_idx,

  input  logic         i_tlb_resolve,
  input  lrq_resolve_t i_lrq_resolve,
  input  logic         i_lrq_full,
  input  stq_resolve_t i_stq_resolve,

  input  commit_t      i_commit,
  input  br_upd_t      i_br_upd,

  output logic         o_ready,
  output logic         o_free,
  output logic         o_finish,
  output cmt_id_t      o_cmt_id
);

  ldq_entry_t r_entry;
  ldq_entry_t w_entry_next;

  rnid_t   w_rs1_rnid;
  rnid_t   w_rs2_rnid;
  logic    w_rs1_hit;
  logic    w_rs2_hit;
  logic    w_rs1_ready_now;
  logic    w_rs2_ready_now;

  logic    w_occupied;
  logic    w_br_flush;
  logic    w_disp_br_flush;
  logic    w_commit_flush;
  logic    w_flush;
  logic    w_own_commit;
  logic    w_ex1_hit;
  logic    w_ex2_hit;
  logic    w_lrq_resolve_match;
  stq_oh_t w_stq_haz_next;

  function automatic logic wr_bus_hit(input rnid_t rnid, input phy_wr_t wr [`PHY_WR_NUM]);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `PHY_WR_NUM; i++) begin
      hit |= wr[i].valid & (wr[i].rnid == rnid);
    end
    return hit;
  endfunction

  // dispatching entry looks at the incoming ids
  assign w_rs1_rnid = i_disp_load ? i_disp.rs1_rnid : r_entry.rs1_rnid;
  assign w_rs2_rnid = i_disp_load ? i_disp.rs2_rnid : r_entry.rs2_rnid;
  assign w_rs1_hit  = wr_bus_hit(w_rs1_rnid, i_phy_wr);
  assign w_rs2_hit  = wr_bus_hit(w_rs2_rnid, i_phy_wr);

  assign w_rs1_ready_now = !r_entry.rs1_valid | r_entry.rs1_ready | w_rs1_hit;
  assign w_rs2_ready_now = !r_entry.rs2_valid | r_entry.rs2_ready | w_rs2_hit;

  assign w_occupied      = r_entry.state != LDQ_INIT;
  assign w_br_flush      = i_br_upd.update & i_br_upd.mispredict &
                           r_entry.br_mask[i_br_upd.brtag] & w_occupied;
  assign w_disp_br_flush = i_br_upd.update & i_br_upd.mispredict &
                           i_disp.br_mask[i_br_upd.brtag];
  assign w_commit_flush  = i_commit.valid & i_commit.flush &
                           (i_commit.cmt_id != r_entry.cmt_id) & w_occupied;
  assign w_flush         = w_br_flush | w_commit_flush;
  assign w_own_commit    = i_commit.valid & (i_commit.cmt_id == r_entry.cmt_id);

  assign w_ex1_hit = i_ex1.valid & (i_ex1.idx == i_my_idx);
  assign w_ex2_hit = i_ex2.valid & (i_ex2.idx == i_my_idx);

  // conflicting request already done in the same cycle
  assign w_lrq_resolve_match = i_lrq_resolve.valid &
                               (i_lrq_resolve.resolve_oh == i_ex2.lrq_oh);

  assign w_stq_haz_next = i_stq_resolve.valid ? r_entry.stq_haz & ~i_stq_resolve.resolve_oh :
                                                r_entry.stq_haz;

  assign o_ready  = (r_entry.state == LDQ_ISSUE_WAIT) & !w_flush &
                    w_rs1_ready_now & w_rs2_ready_now;
  assign o_free   = !w_occupied;
  assign o_finish = w_own_commit &
                    ((r_entry.state == LDQ_WAIT_COMPLETE) | (r_entry.state == LDQ_DEAD));
  assign o_cmt_id = r_entry.cmt_id;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry       <= '0;
      r_entry.state <= LDQ_INIT;
    end else begin
      r_entry <= w_entry_next;
    end
  end

  always_comb begin
    w_entry_next = r_entry;
    w_entry_next.rs1_ready = r_entry.rs1_ready | w_rs1_hit;
    w_entry_next.rs2_ready = r_entry.rs2_ready | w_rs2_hit;

    case (r_entry.state)
      LDQ_INIT: begin
        if (i_disp_load) begin
          w_entry_next.state      = w_disp_br_flush ? LDQ_DEAD : LDQ_ISSUE_WAIT;
          w_entry_next.cmt_id     = i_disp_cmt_id;
          w_entry_next.br_mask    = i_disp.br_mask;
          w_entry_next.rs1_valid  = i_disp.rs1_valid;
          w_entry_next.rs1_rnid   = i_disp.rs1_rnid;
          w_entry_next.rs1_ready  = w_rs1_hit;
          w_entry_next.rs2_valid  = i_disp.rs2_valid;
          w_entry_next.rs2_rnid   = i_disp.rs2_rnid;
          w_entry_next.rs2_ready  = w_rs2_hit;
          w_entry_next.lrq_haz_oh = '0;
          w_entry_next.stq_haz    = '0;
        end
      end
      LDQ_ISSUE_WAIT: begin
        if (w_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (o_ready & i_picked) begin
          w_entry_next.state = LDQ_ISSUED;
        end
      end
      LDQ_ISSUED: begin
        if (w_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (w_ex1_hit) begin
          w_entry_next.state = i_ex1.tlb_miss ? LDQ_TLB_HAZ : LDQ_EX2_RUN;
        end
      end
      LDQ_TLB_HAZ: begin
        if (w_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (i_tlb_resolve) begin
          w_entry_next.state = LDQ_ISSUE_WAIT;
        end
      end
      LDQ_EX2_RUN: begin
        if (w_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (w_ex2_hit) begin
          w_entry_next.lrq_haz_oh = i_ex2.lrq_oh;
          w_entry_next.stq_haz    = i_ex2.stq_haz;
          case (i_ex2.hazard)
            HAZ_NONE:         w_entry_next.state = LDQ_WAIT_COMPLETE;
            HAZ_LRQ_CONFLICT: w_entry_next.state = w_lrq_resolve_match ? LDQ_ISSUE_WAIT :
                                                                         LDQ_LRQ_CONFLICT;
            HAZ_LRQ_FULL:     w_entry_next.state = LDQ_LRQ_FULL;
            HAZ_STQ_DEPEND:   w_entry_next.state = LDQ_STQ_HAZ;
            // l1d conflict, lrq assigned: rerun at once
            default:          w_entry_next.state = LDQ_ISSUE_WAIT;
          endcase
        end
      end
      LDQ_LRQ_CONFLICT: begin
        if (w_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (i_lrq_resolve.valid &&
                     i_lrq_resolve.resolve_oh == r_entry.lrq_haz_oh) begin
          w_entry_next.state = LDQ_ISSUE_WAIT;
        end else if (~|(i_lrq_resolve.entry_valids & r_entry.lrq_haz_oh)) begin
          w_entry_next.state = LDQ_ISSUE_WAIT;  // blocking request gone
        end
      end
      LDQ_LRQ_FULL: begin
        if (w_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else if (!i_lrq_full) begin
          w_entry_next.state = LDQ_ISSUE_WAIT;
        end
      end
      LDQ_STQ_HAZ: begin
        if (w_flush) begin
          w_entry_next.state = LDQ_DEAD;
        end else begin
          w_entry_next.stq_haz = w_stq_haz_next;
          if (w_stq_haz_next == '0) begin
            w_entry_next.state = LDQ_ISSUE_WAIT;
          end
        end
      end
      LDQ_WAIT_COMPLETE, LDQ_DEAD: begin
        if (w_own_commit) begin
          w_entry_next.state  = LDQ_INIT;
          w_entry_next.cmt_id = '0;  // keep stale id off the commit compare
        end
      end
      default: w_entry_next.state = LDQ_INIT;
    endcase

    // resolved branch no longer guards this load
    if (i_br_upd.update) begin
      w_entry_next.br_mask[i_br_upd.brtag] = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/ldq_lsu_pkg.sv
`default_nettype none

`include "ldq_defines.svh"

package ldq_lsu_pkg;

  import ldq_core_pkg::*;

  typedef logic [$clog2(`LDQ_SIZE)-1:0] ldq_idx_t;
  typedef logic [`LRQ_SIZE-1:0]         lrq_oh_t;
  typedef logic [`STQ_SIZE-1:0]         stq_oh_t;

  typedef enum logic [3:0] {
    LDQ_INIT,
    LDQ_ISSUE_WAIT,
    LDQ_ISSUED,
    LDQ_TLB_HAZ,
    LDQ_EX2_RUN,
    LDQ_LRQ_CONFLICT,
    LDQ_LRQ_FULL,
    LDQ_STQ_HAZ,
    LDQ_WAIT_COMPLETE,
    LDQ_DEAD
  } ldq_state_t;

  typedef enum logic [2:0] {
    HAZ_NONE,
    HAZ_L1D_CONFLICT,
    HAZ_LRQ_CONFLICT,
    HAZ_LRQ_FULL,
    HAZ_STQ_DEPEND,
    HAZ_LRQ_ASSIGNED
  } hazard_t;

  typedef struct packed {
    logic     valid;
    ldq_idx_t idx;
    logic     tlb_miss;
  } ex1_upd_t;

  typedef struct packed {
    logic     valid;
    ldq_idx_t idx;
    hazard_t  hazard;
    lrq_oh_t  lrq_oh;
    stq_oh_t  stq_haz;  // older stores the load waits on
  } ex2_upd_t;

  typedef struct packed {
    logic    valid;
    lrq_oh_t resolve_oh;
    lrq_oh_t entry_valids;
  } lrq_resolve_t;

  typedef struct packed {
    logic    valid;
    stq_oh_t resolve_oh;
  } stq_resolve_t;

  typedef struct packed {
    ldq_state_t state;
    cmt_id_t    cmt_id;
    br_mask_t   br_mask;
    logic       rs1_valid;
    rnid_t      rs1_rnid;
    logic       rs1_ready;
    logic       rs2_valid;
    rnid_t      rs2_rnid;
    logic       rs2_ready;
    lrq_oh_t    lrq_haz_oh;
    stq_oh_t    stq_haz;
  } ldq_entry_t;

endpackage

`default_nettype wire

// File: hw/ldq_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "ldq_defines.svh"

module ldq_select
  import ldq_lsu_pkg::*;
(
  input  logic [`LDQ_SIZE-1:0] i_free,
  input  logic [`LDQ_SIZE-1:0] i_ready,
  input  logic                 i_pipe_ready,

  output logic [`LDQ_SIZE-1:0] o_alloc_oh,
  output logic                 o_full,
  output logic [`LDQ_SIZE-1:0] o_issue_oh,
  output logic                 o_issue_valid,
  output ldq_idx_t             o_issue_idx
);

  logic [`LDQ_SIZE-1:0] w_ready_oh;

  // isolate the lowest set bit
  function automatic logic [`LDQ_SIZE-1:0] lowest_oh(input logic [`LDQ_SIZE-1:0] req);
    return req & (~req + 1'b1);
  endfunction

  assign o_alloc_oh = lowest_oh(i_free);
  assign o_full     = ~|i_free;

  assign w_ready_oh    = lowest_oh(i_ready);
  assign o_issue_oh    = i_pipe_ready ? w_ready_oh : '0;
  assign o_issue_valid = i_pipe_ready & |i_ready;

  always_comb begin
    o_issue_idx = '0;
    for (int i = 0; i < `LDQ_SIZE; i++) begin
      if (w_ready_oh[i]) begin
        o_issue_idx = ldq_idx_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: ldq.f
+incdir+hw
hw/ldq_core_pkg.sv
hw/ldq_lsu_pkg.sv
hw/ldq_entry.sv
hw/ldq_select.sv
hw/ldq.sv
tb/ldq_chk.sv
tb/tb_ldq_checker.sv
tb/tb_ldq.sv

// File: tb/ldq_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "ldq_defines.svh"

module ldq_chk
  import ldq_core_pkg::*, ldq_lsu_pkg::*;
(
  input logic                 i_clk,
  input logic                 i_reset_n,
  input logic                 i_pipe_ready,
  input logic                 i_issue_valid,
  input ldq_idx_t             i_issue_idx,
  input cmt_id_t              i_issue_cmt_id,
  input logic                 i_finish_valid,
  input cmt_id_t              i_finish_cmt_id,
  input logic                 i_full,
  input logic [`LDQ_SIZE-1:0] i_free,
  input ex2_upd_t             i_ex2
);

  int fail_count = 0;

  a_issue_needs_pipe: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_issue_valid |-> i_pipe_ready)
    else begin
      $error("issue while the load pipe is stalled");
      fail_count++;
    end

  a_issue_occupied: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_issue_valid |-> !i_free[i_issue_idx])
    else begin
      $error("issue from a free entry");
      fail_count++;
    end

  // assigned lrq slot must name exactly one entry
  a_lrq_assigned_oh: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_ex2.valid && i_ex2.hazard == HAZ_LRQ_ASSIGNED) |-> $onehot(i_ex2.lrq_oh))
    else begin
      $error("lrq assigned without a one-hot lrq index");
      fail_count++;
    end

  a_outputs_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown({i_issue_valid, i_issue_idx, i_issue_cmt_id,
                 i_finish_valid, i_finish_cmt_id, i_full}))
    else begin
      $error("unknown value on a queue output");
      fail_count++;
    end

endmodule

bind ldq ldq_chk u_chk (
  .i_clk           (i_clk),
  .i_reset_n       (i_reset_n),
  .i_pipe_ready    (i_pipe_ready),
  .i_issue_valid   (o_issue_valid),
  .i_issue_idx     (o_issue_idx),
  .i_issue_cmt_id  (o_issue_cmt_id),
  .i_finish_valid  (o_finish_valid),
  .i_finish_cmt_id (o_finish_cmt_id),
  .i_full          (o_full),
  .i_free          (w_free),
  .i_ex2           (i_ex2)
);

`default_nettype wire

// File: tb/tb_ldq.sv
`timescale 1ns/100ps
`default_nettype none

`include "ldq_defines.svh"

module tb_ldq
  import ldq_core_pkg::*, ldq_lsu_pkg::*;
();

  localparam int NUM_LOADS   = 200;
  localparam int CYCLE_LIMIT = 40 * NUM_LOADS + 100;
  localparam int NUM_IDS     = 2 ** `CMT_ID_W;

  logic         i_clk;
  logic         i_reset_n;
  logic         i_disp_valid;
  disp_t        i_disp;
  cmt_id_t      i_disp_cmt_id;
  phy_wr_t      i_phy_wr [`PHY_WR_NUM];
  logic         i_pipe_ready;
  ex1_upd_t     i_ex1;
  ex2_upd_t     i_ex2;
  logic         i_tlb_resolve;
  lrq_resolve_t i_lrq_resolve;
  logic         i_lrq_full;
  stq_resolve_t i_stq_resolve;
  commit_t      i_commit;
  br_upd_t      i_br_upd;
  logic         o_issue_valid;
  ldq_idx_t     o_issue_idx;
  cmt_id_t      o_issue_cmt_id;
  logic         o_finish_valid;
  cmt_id_t      o_finish_cmt_id;
  logic         o_full;

  int          err_count;
  int          check_count;
  int          cycle_count = 0;
  logic [31:0] lfsr;

  // what the stimulus knows about each load in flight
  cmt_id_t  live_q [$];
  logic     finishable [NUM_IDS];
  br_mask_t mask_of [NUM_IDS];
  int       n_disp;
  int       n_commit;
  logic     issued;
  ldq_idx_t iss_idx;
  cmt_id_t  iss_id;
  logic     ex2_pend;
  ldq_idx_t ex2_idx;
  cmt_id_t  ex2_id;

  ldq u_ldq (.*);

  tb_ldq_checker u_checker (
    .i_issue_valid   (o_issue_valid),
    .i_issue_idx     (o_issue_idx),
    .i_issue_cmt_id  (o_issue_cmt_id),
    .i_finish_valid  (o_finish_valid),
    .i_finish_cmt_id (o_finish_cmt_id),
    .i_full          (o_full),
    .o_err_count     (err_count),
    .o_check_count   (check_count),
    .*
  );

  always #10 i_clk = ~i_clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  task automatic clear_inputs();
    i_disp_valid  = 1'b0;
    i_disp        = '0;
    i_disp_cmt_id = '0;
    foreach (i_phy_wr[b]) i_phy_wr[b] = '0;
    i_pipe_ready  = 1'b0;
    i_ex1         = '0;
    i_ex2         = '0;
    i_tlb_resolve = 1'b0;
    i_lrq_resolve = '0;
    i_lrq_full    = 1'b0;
    i_stq_resolve = '0;
    i_commit      = '0;
    i_br_upd      = '0;
  endtask

  task automatic drive_cycle();
    logic [2:0] r;
    hazard_t    haz;
    cmt_id_t    id;
    // in-order commit of the oldest load once it can finish
    i_commit = '0;
    if (live_q.size() > 0 && finishable[live_q[0]] && rand_bits(1) != 0) begin
      i_commit.valid  = 1'b1;
      i_commit.cmt_id = live_q.pop_front();
      i_commit.flush  = rand_bits(4) == 0;
      if (i_commit.flush) begin
        foreach (live_q[k]) finishable[live_q[k]] = 1'b1;
      end
      n_commit++;
    end
    // ex2 one cycle after a clean ex1
    i_ex2 = '0;
    if (ex2_pend) begin
      r = 3'(rand_bits(3));
      haz = (r > 3'd5) ? HAZ_NONE : hazard_t'(r);
      i_ex2.valid   = 1'b1;
      i_ex2.idx     = ex2_idx;
      i_ex2.hazard  = haz;
      i_ex2.lrq_oh  = lrq_oh_t'(1) << rand_bits(2);
      i_ex2.stq_haz = stq_oh_t'(rand_bits(4));
      if (haz == HAZ_NONE) finishable[ex2_id] = 1'b1;
    end
    ex2_pend = 1'b0;
    i_ex1 = '0;
    if (issued) begin
      i_ex1.valid    = 1'b1;
      i_ex1.idx      = iss_idx;
      i_ex1.tlb_miss = rand_bits(3) == 0;
      ex2_pend = !i_ex1.tlb_miss;
      ex2_idx  = iss_idx;
      ex2_id   = iss_id;
    end
    foreach (i_phy_wr[b]) begin
      i_phy_wr[b].valid = rand_bits(1) != 0;
      i_phy_wr[b].rnid  = rnid_t'(rand_bits(4));
    end
    i_pipe_ready             = rand_bits(2) != 0;
    i_tlb_resolve            = rand_bits(2) == 0;
    i_lrq_resolve.valid      = rand_bits(1) != 0;
    i_lrq_resolve.resolve_oh = lrq_oh_t'(1) << rand_bits(2);
    i_lrq_resolve.entry_valids = lrq_oh_t'(rand_bits(4));
    i_lrq_full               = rand_bits(1) != 0;
    i_stq_resolve.valid      = rand_bits(1) != 0;
    i_stq_resolve.resolve_oh = stq_oh_t'(rand_bits(4));
    i_disp_valid = 1'b0;
    i_disp       = '0;
    if (!o_full && !i_commit.flush && n_disp < NUM_LOADS && rand_bits(1) != 0) begin
      id = cmt_id_t'(n_disp);
      i_disp_valid     = 1'b1;
      i_disp_cmt_id    = id;
      i_disp.rs1_valid = rand_bits(1) != 0;
      i_disp.rs1_rnid  = rnid_t'(rand_bits(4));
      i_disp.rs2_valid = rand_bits(1) != 0;
      i_disp.rs2_rnid  = rnid_t'(rand_bits(4));
      i_disp.br_mask   = br_mask_t'(rand_bits(4) & rand_bits(4));
      live_q.push_back(id);
      finishable[id] = 1'b0;
      mask_of[id]    = i_disp.br_mask;
      n_disp++;
    end
    i_br_upd = '0;
    if (rand_bits(2) == 0) begin
      i_br_upd.update     = 1'b1;
      i_br_upd.mispredict = rand_bits(3) == 0;
      i_br_upd.brtag      = brtag_t'(rand_bits(2));
      foreach (live_q[k]) begin
        if (i_br_upd.mispredict && mask_of[live_q[k]][i_br_upd.brtag]) begin
          finishable[live_q[k]] = 1'b1;  // killed, waits only for its commit
        end
        mask_of[live_q[k]][i_br_upd.brtag] = 1'b0;
      end
    end
  endtask

  task automatic report_counts();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, err_count, u_ldq.u_chk.fail_count);
  endtask

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: loads still outstanding after %0d cycles", CYCLE_LIMIT);
      report_counts();
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    lfsr      = 32'h16f17981;
    i_clk     = 1'b0;
    i_reset_n = 1'b0;
    clear_inputs();
    n_disp   = 0;
    n_commit = 0;
    issued   = 1'b0;
    ex2_pend = 1'b0;
    repeat (8) @(posedge i_clk);
    #2 i_reset_n = 1'b1;
    while (n_commit < NUM_LOADS) begin
      @(negedge i_clk);
      issued  = o_issue_valid;
      iss_idx = o_issue_idx;
      iss_id  = o_issue_cmt_id;
      @(posedge i_clk);
      #2;
      drive_cycle();
    end
    @(posedge i_clk);
    #2 clear_inputs();
    repeat (2) @(negedge i_clk);
    report_counts();
    if (err_count == 0 && u_ldq.u_chk.fail_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/tb_ldq_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "ldq_defines.svh"

module tb_ldq_checker
  import ldq_core_pkg::*, ldq_lsu_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_reset_n,
  input  logic         i_disp_valid,
  input  disp_t        i_disp,
  input  cmt_id_t      i_disp_cmt_id,
  input  phy_wr_t      i_phy_wr [`PHY_WR_NUM],
  input  logic         i_pipe_ready,
  input  ex1_upd_t     i_ex1,
  input  ex2_upd_t     i_ex2,
  input  logic         i_tlb_resolve,
  input  lrq_resolve_t i_lrq_resolve,
  input  logic         i_lrq_full,
  input  stq_resolve_t i_stq_resolve,
  input  commit_t      i_commit,
  input  br_upd_t      i_br_upd,
  input  logic         i_issue_valid,
  input  ldq_idx_t     i_issue_idx,
  input  cmt_id_t      i_issue_cmt_id,
  input  logic         i_finish_valid,
  input  cmt_id_t      i_finish_cmt_id,
  input  logic         i_full,
  output int           o_err_count,
  output int           o_check_count
);

  ldq_entry_t model [`LDQ_SIZE];
  int         err_count = 0;
  int         check_count = 0;

  assign o_err_count   = err_count;
  assign o_check_count = check_count;

  function automatic logic written(input rnid_t rnid);
    logic hit;
    hit = 1'b0;
    foreach (i_phy_wr[b]) begin
      hit |= i_phy_wr[b].valid && (i_phy_wr[b].rnid == rnid);
    end
    return hit;
  endfunction

  function automatic logic killed(input ldq_entry_t e);
    if (e.state == LDQ_INIT) begin
      return 1'b0;
    end
    if (i_br_upd.update && i_br_upd.mispredict && e.br_mask[i_br_upd.brtag]) begin
      return 1'b1;
    end
    return i_commit.valid && i_commit.flush && (i_commit.cmt_id != e.cmt_id);
  endfunction

  function automatic logic can_issue(input ldq_entry_t e);
    return (e.state == LDQ_ISSUE_WAIT) && !killed(e) &&
           (!e.rs1_valid || e.rs1_ready || written(e.rs1_rnid)) &&
           (!e.rs2_valid || e.rs2_ready || written(e.rs2_rnid));
  endfunction

  function automatic logic can_finish(input ldq_entry_t e);
    return i_commit.valid && (i_commit.cmt_id == e.cmt_id) &&
           (e.state == LDQ_WAIT_COMPLETE || e.state == LDQ_DEAD);
  endfunction

  function automatic ldq_entry_t next_state(input ldq_entry_t e, input ldq_idx_t idx,
                                            input logic load, input logic picked);
    ldq_entry_t n;
    stq_oh_t    left;
    n = e;
    n.rs1_ready = e.rs1_ready | written(e.rs1_rnid);
    n.rs2_ready = e.rs2_ready | written(e.rs2_rnid);
    left = e.stq_haz & ~(i_stq_resolve.valid ? i_stq_resolve.resolve_oh : '0);
    if (e.state == LDQ_INIT) begin
      if (load) begin
        n = '0;
        n.state = (i_br_upd.update && i_br_upd.mispredict &&
                   i_disp.br_mask[i_br_upd.brtag]) ? LDQ_DEAD : LDQ_ISSUE_WAIT;
        n.cmt_id    = i_disp_cmt_id;
        n.br_mask   = i_disp.br_mask;
        n.rs1_valid = i_disp.rs1_valid;
        n.rs1_rnid  = i_disp.rs1_rnid;
        n.rs1_ready = written(i_disp.rs1_rnid);
        n.rs2_valid = i_disp.rs2_valid;
        n.rs2_rnid  = i_disp.rs2_rnid;
        n.rs2_ready = written(i_disp.rs2_rnid);
      end
    end else if (e.state == LDQ_WAIT_COMPLETE || e.state == LDQ_DEAD) begin
      if (can_finish(e)) begin
        n = '0;  // free again
      end
    end else if (killed(e)) begin
      n.state = LDQ_DEAD;
    end else begin
      case (e.state)
        LDQ_ISSUE_WAIT: if (picked) n.state = LDQ_ISSUED;
        LDQ_ISSUED: begin
          if (i_ex1.valid && i_ex1.idx == idx) begin
            n.state = i_ex1.tlb_miss ? LDQ_TLB_HAZ : LDQ_EX2_RUN;
          end
        end
        LDQ_TLB_HAZ: if (i_tlb_resolve) n.state = LDQ_ISSUE_WAIT;
        LDQ_EX2_RUN: begin
          if (i_ex2.valid && i_ex2.idx == idx) begin
            n.lrq_haz_oh = i_ex2.lrq_oh;
            n.stq_haz    = i_ex2.stq_haz;
            case (i_ex2.hazard)
              HAZ_NONE:         n.state = LDQ_WAIT_COMPLETE;
              HAZ_LRQ_CONFLICT: n.state = (i_lrq_resolve.valid &&
                                           i_lrq_resolve.resolve_oh == i_ex2.lrq_oh) ?
                                          LDQ_ISSUE_WAIT : LDQ_LRQ_CONFLICT;
              HAZ_LRQ_FULL:     n.state = LDQ_LRQ_FULL;
              HAZ_STQ_DEPEND:   n.state = LDQ_STQ_HAZ;
              default:          n.state = LDQ_ISSUE_WAIT;
            endcase
          end
        end
        LDQ_LRQ_CONFLICT: begin
          if ((i_lrq_resolve.valid && i_lrq_resolve.resolve_oh == e.lrq_haz_oh) ||
              (i_lrq_resolve.entry_valids & e.lrq_haz_oh) == '0) begin
            n.state = LDQ_ISSUE_WAIT;
          end
        end
        LDQ_LRQ_FULL: if (!i_lrq_full) n.state = LDQ_ISSUE_WAIT;
        LDQ_STQ_HAZ: begin
          n.stq_haz = left;
          if (left == '0) n.state = LDQ_ISSUE_WAIT;
        end
        default: ;
      endcase
    end
    if (i_br_upd.update) begin
      n.br_mask[i_br_upd.brtag] = 1'b0;
    end
    return n;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge i_clk) begin
    logic [`LDQ_SIZE-1:0] ready;
    logic [`LDQ_SIZE-1:0] fin;
    logic [`LDQ_SIZE-1:0] occ;
    int                   pick;
    int                   slot;
    cmt_id_t              fin_id;
    logic                 exp_issue;
    if (!i_reset_n) begin
      foreach (model[i]) model[i] = '0;
    end else begin
      pick = 0;
      slot = 0;
      fin_id = '0;
      for (int i = `LDQ_SIZE - 1; i >= 0; i--) begin  // lowest index wins
        ready[i] = can_issue(model[i]);
        occ[i]   = model[i].state != LDQ_INIT;
        fin[i]   = can_finish(model[i]);
        if (ready[i]) pick = i;
        if (!occ[i]) slot = i;
        if (fin[i]) fin_id = model[i].cmt_id;
      end
      exp_issue = i_pipe_ready && (|ready);
      compare("o_issue_valid", i_issue_valid, exp_issue);
      if (exp_issue) begin
        compare("o_issue_idx", i_issue_idx, pick);
        compare("o_issue_cmt_id", i_issue_cmt_id, model[pick].cmt_id);
      end
      compare("o_finish_valid", i_finish_valid, |fin);
      if (|fin) begin
        compare("o_finish_cmt_id", i_finish_cmt_id, fin_id);
      end
      compare("o_full", i_full, &occ);
      for (int i = 0; i < `LDQ_SIZE; i++) begin
        model[i] = next_state(model[i], ldq_idx_t'(i),
                              i_disp_valid && !(&occ) && (slot == i),
                              exp_issue && (pick == i));
      end
    end
  end

endmodule

`default_nettype wire
